// ==== smap_cfg.svh ====
`ifndef SMAP_CFG_SVH
`define SMAP_CFG_SVH

// Register map
`define SMAP_REG_STATUS 2'd0
`define SMAP_REG_OREGS  2'd1
`define SMAP_REG_DATA   2'd2
`define SMAP_REG_CTRL   2'd3

`define SMAP_MODE_SLAVE 3'b110  // M[2:0] for slave SelectMAP

`define SMAP_SYNC_STAGES 2

// Pin levels out of reset
`define SMAP_RST_PROG_N    1'b1
`define SMAP_RST_INIT_N    1'b1
`define SMAP_RST_INIT_N_OE 1'b1
`define SMAP_RST_RDWR_N    1'b0
`define SMAP_RST_STATUS    3'b001  // busy 0, done 0, init_n 1

`endif

// ==== smap_pkg.sv ====
`default_nettype none

package smap_pkg;

  // Register address on the Wishbone side
  typedef logic [1:0] reg_addr_t;

  // Register contents and configuration bytes
  typedef logic [7:0] reg_byte_t;

  // One Wishbone request as seen by the decoder
  typedef struct packed {
    logic      cyc;
    logic      stb;
    logic      we;
    reg_addr_t adr;
    reg_byte_t dat;
  } wb_req_t;

  // Decoded register writes, one strobe per writable register
  typedef struct packed {
    logic      wr_oregs;
    logic      wr_ctrl;
    logic      wr_data;
    reg_byte_t dat;
  } reg_access_t;

endpackage

`default_nettype wire

// ==== wb_decode.sv ====
`default_nettype none

`include "smap_cfg.svh"

module wb_decode (
  input  wire                   wb_clk_i,
  input  wire                   wb_rst_i,
  input  wire smap_pkg::wb_req_t req_i,
  output logic                  ack_o,
  output smap_pkg::reg_access_t access_o
);

  logic take;
  logic wr_take;

  // A transfer is taken once per cycle pair, never while ack is up
  assign take    = req_i.cyc & req_i.stb & ~ack_o;
  assign wr_take = take & req_i.we;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= take;  // Single cycle ack
    end
  end

  // Write strobes, only for the addresses that hold state
  always_comb begin
    access_o.wr_oregs = 1'b0;
    access_o.wr_ctrl  = 1'b0;
    access_o.wr_data  = 1'b0;
    access_o.dat      = req_i.dat;
    if (wr_take) begin
      case (req_i.adr)
        `SMAP_REG_OREGS: access_o.wr_oregs = 1'b1;
        `SMAP_REG_DATA:  access_o.wr_data  = 1'b1;
        `SMAP_REG_CTRL:  access_o.wr_ctrl  = 1'b1;
        default: begin
          // STATUS is read only, write is acked and dropped
          access_o.wr_oregs = 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== smap_ctrl.sv ====
`default_nettype none

`include "smap_cfg.svh"

module smap_ctrl (
  input  wire                       wb_clk_i,
  input  wire                       wb_rst_i,
  input  wire smap_pkg::reg_access_t access_i,
  output logic                      prog_n_o,
  output logic                      init_n_o,
  output logic                      init_n_oe_o,
  output logic                      rdwr_n_o,
  output smap_pkg::reg_byte_t       oregs_o,
  output smap_pkg::reg_byte_t       ctrl_o
);

  logic prog_n_q;
  logic init_n_q;
  logic rdwr_n_q;
  logic init_n_oe_q;

  // Pin level register
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      prog_n_q <= `SMAP_RST_PROG_N;
      init_n_q <= `SMAP_RST_INIT_N;
      rdwr_n_q <= `SMAP_RST_RDWR_N;
    end else if (access_i.wr_oregs) begin
      prog_n_q <= access_i.dat[0];
      init_n_q <= access_i.dat[1];
      rdwr_n_q <= access_i.dat[2];
    end
  end

  // INIT_B driver enable
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      init_n_oe_q <= `SMAP_RST_INIT_N_OE;
    end else if (access_i.wr_ctrl) begin
      init_n_oe_q <= access_i.dat[0];
    end
  end

  assign prog_n_o    = prog_n_q;
  assign init_n_o    = init_n_q;
  assign rdwr_n_o    = rdwr_n_q;
  assign init_n_oe_o = init_n_oe_q;

  // Readback views, unused bits zero
  assign oregs_o = {5'b0, rdwr_n_q, init_n_q, prog_n_q};
  assign ctrl_o  = {7'b0, init_n_oe_q};

endmodule

`default_nettype wire

// ==== smap_data.sv ====
`default_nettype none

module smap_data (
  input  wire                       wb_clk_i,
  input  wire                       wb_rst_i,
  input  wire smap_pkg::reg_access_t access_i,
  input  wire                       sm_cs_n_i,
  output smap_pkg::reg_byte_t       d_o,
  output logic                      cs_n_o
);

  smap_pkg::reg_byte_t d_q;
  logic                cs_pulse_n;

  // Byte holds on the pins until the next data write
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      d_q <= '0;
    end else if (access_i.wr_data) begin
      d_q <= access_i.dat;
    end
  end

  // Low for the one cycle the new byte first sits on d_o
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      cs_pulse_n <= 1'b1;
    end else begin
      cs_pulse_n <= ~access_i.wr_data;
    end
  end

  assign d_o    = d_q;
  assign cs_n_o = cs_pulse_n & sm_cs_n_i;  // Either strobe pulls CS_B low

endmodule

`default_nettype wire

// ==== smap_readback.sv ====
`default_nettype none

`include "smap_cfg.svh"

module smap_readback (
  input  wire                     wb_clk_i,
  input  wire                     wb_rst_i,
  input  wire smap_pkg::reg_addr_t adr_i,
  input  wire                     done_i,
  input  wire                     busy_i,
  input  wire                     init_n_i,
  input  wire smap_pkg::reg_byte_t oregs_i,
  input  wire smap_pkg::reg_byte_t ctrl_i,
  input  wire smap_pkg::reg_byte_t data_i,
  output smap_pkg::reg_byte_t     dat_o
);

  // Each stage is {busy, done, init_n}, same order as STATUS
  logic [`SMAP_SYNC_STAGES-1:0][2:0] stat_sync;
  logic [2:0]                        stat;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      stat_sync <= {`SMAP_SYNC_STAGES{`SMAP_RST_STATUS}};
    end else begin
      stat_sync <= {stat_sync[`SMAP_SYNC_STAGES-2:0], {busy_i, done_i, init_n_i}};
    end
  end

  assign stat = stat_sync[`SMAP_SYNC_STAGES-1];  // Last stage

  always_comb begin
    case (adr_i)
      `SMAP_REG_STATUS: dat_o = {5'b0, stat};
      `SMAP_REG_OREGS:  dat_o = oregs_i;
      `SMAP_REG_DATA:   dat_o = data_i;
      `SMAP_REG_CTRL:   dat_o = ctrl_i;
      default:          dat_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== smap_cfg_top.sv ====
`default_nettype none

`include "smap_cfg.svh"

module smap_cfg_top (
  input  wire                      wb_clk_i,
  input  wire                      wb_rst_i,
  input  wire                      wb_cyc_i,
  input  wire                      wb_stb_i,
  input  wire                      wb_we_i,
  input  wire smap_pkg::reg_addr_t wb_adr_i,
  input  wire smap_pkg::reg_byte_t wb_dat_i,
  output smap_pkg::reg_byte_t      wb_dat_o,
  output logic                     wb_ack_o,
  input  wire                      sm_cs_n_i,

  output logic                     v5c_prog_n_o,
  output logic                     v5c_init_n_o,
  output logic                     v5c_init_n_oe_o,
  output logic                     v5c_rdwr_n_o,
  output logic                     v5c_cs_n_o,
  output smap_pkg::reg_byte_t      v5c_d_o,
  output logic [2:0]               v5c_mode_o,
  input  wire                      v5c_done_i,
  input  wire                      v5c_busy_i,
  input  wire                      v5c_init_n_i
);

  smap_pkg::wb_req_t     req;
  smap_pkg::reg_access_t access;
  smap_pkg::reg_byte_t   oregs;
  smap_pkg::reg_byte_t   ctrl;

  assign req.cyc = wb_cyc_i;
  assign req.stb = wb_stb_i;
  assign req.we  = wb_we_i;
  assign req.adr = wb_adr_i;
  assign req.dat = wb_dat_i;

  assign v5c_mode_o = `SMAP_MODE_SLAVE;  // Slave SelectMAP only

  wb_decode u_decode (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .req_i    (req),
    .ack_o    (wb_ack_o),
    .access_o (access)
  );

  smap_ctrl u_ctrl (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .access_i    (access),
    .prog_n_o    (v5c_prog_n_o),
    .init_n_o    (v5c_init_n_o),
    .init_n_oe_o (v5c_init_n_oe_o),
    .rdwr_n_o    (v5c_rdwr_n_o),
    .oregs_o     (oregs),
    .ctrl_o      (ctrl)
  );

  smap_data u_data (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .access_i  (access),
    .sm_cs_n_i (sm_cs_n_i),
    .d_o       (v5c_d_o),
    .cs_n_o    (v5c_cs_n_o)
  );

  // DATA reads back straight from the pin register
  smap_readback u_readback (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .adr_i    (wb_adr_i),
    .done_i   (v5c_done_i),
    .busy_i   (v5c_busy_i),
    .init_n_i (v5c_init_n_i),
    .oregs_i  (oregs),
    .ctrl_i   (ctrl),
    .data_i   (v5c_d_o),
    .dat_o    (wb_dat_o)
  );

endmodule

`default_nettype wire

// ==== smap_cfg_asserts.sv ====
`default_nettype none

module smap_cfg_asserts (
  input wire       wb_clk_i,
  input wire       wb_rst_i,
  input wire       ack_i,
  input wire       cs_pulse_n_i
);

  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0;  // Read by the testbench at the end of the run

  // Classic cycle, so ack never stays up for a second clock
  ack_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i) ack_i |=> !ack_i)
    else begin
      $error("wb_ack_o stayed high for two cycles");
      fail_cnt++;
    end

  ack_after_reset: assert property (@(posedge wb_clk_i) $fell(wb_rst_i) |-> !ack_i)
    else begin
      $error("wb_ack_o high in the first cycle after reset");
      fail_cnt++;
    end

  cs_one_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
                                 !cs_pulse_n_i |=> cs_pulse_n_i)
    else begin
      $error("Internal chip-select pulse longer than one cycle");
      fail_cnt++;
    end

  cs_with_ack: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
                                !cs_pulse_n_i |-> ack_i)
    else begin
      $error("Internal chip-select pulse outside an ack cycle");
      fail_cnt++;
    end

endmodule

bind smap_cfg_top smap_cfg_asserts u_asserts (
  .wb_clk_i     (wb_clk_i),
  .wb_rst_i     (wb_rst_i),
  .ack_i        (wb_ack_o),
  .cs_pulse_n_i (u_data.cs_pulse_n)
);

`default_nettype wire

// ==== smap_cfg_tb.sv ====
`default_nettype none

`include "smap_cfg.svh"

module smap_cfg_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT_CYCLES = 2000;  // Well above the ~220 cycles the tests take

  // Pin levels seen in the ack cycle of a write
  typedef struct packed {
    logic                prog_n;
    logic                init_n;
    logic                init_n_oe;
    logic                rdwr_n;
    logic                cs_n;
    smap_pkg::reg_byte_t d;
  } pin_snap_t;

  logic                wb_clk_i = 1'b0;
  logic                wb_rst_i;
  logic                wb_cyc_i;
  logic                wb_stb_i;
  logic                wb_we_i;
  smap_pkg::reg_addr_t wb_adr_i;
  smap_pkg::reg_byte_t wb_dat_i;
  smap_pkg::reg_byte_t wb_dat_o;
  logic                wb_ack_o;
  logic                sm_cs_n_i;
  logic                v5c_prog_n_o;
  logic                v5c_init_n_o;
  logic                v5c_init_n_oe_o;
  logic                v5c_rdwr_n_o;
  logic                v5c_cs_n_o;
  smap_pkg::reg_byte_t v5c_d_o;
  logic [2:0]          v5c_mode_o;
  logic                v5c_done_i;
  logic                v5c_busy_i;
  logic                v5c_init_n_i;

  int                  errors;
  int                  cycle_cnt = 0;
  int                  cs_low_cnt = 0;  // Low cycles seen on CS_B since reset
  logic [31:0]         rng_state;
  pin_snap_t           snap;
  smap_pkg::reg_byte_t exp_oregs;  // Reference model of the registers
  smap_pkg::reg_byte_t exp_ctrl;
  smap_pkg::reg_byte_t exp_data;

  smap_cfg_top dut (
    .wb_clk_i        (wb_clk_i),
    .wb_rst_i        (wb_rst_i),
    .wb_cyc_i        (wb_cyc_i),
    .wb_stb_i        (wb_stb_i),
    .wb_we_i         (wb_we_i),
    .wb_adr_i        (wb_adr_i),
    .wb_dat_i        (wb_dat_i),
    .wb_dat_o        (wb_dat_o),
    .wb_ack_o        (wb_ack_o),
    .sm_cs_n_i       (sm_cs_n_i),
    .v5c_prog_n_o    (v5c_prog_n_o),
    .v5c_init_n_o    (v5c_init_n_o),
    .v5c_init_n_oe_o (v5c_init_n_oe_o),
    .v5c_rdwr_n_o    (v5c_rdwr_n_o),
    .v5c_cs_n_o      (v5c_cs_n_o),
    .v5c_d_o         (v5c_d_o),
    .v5c_mode_o      (v5c_mode_o),
    .v5c_done_i      (v5c_done_i),
    .v5c_busy_i      (v5c_busy_i),
    .v5c_init_n_i    (v5c_init_n_i)
  );

  always #2 wb_clk_i = ~wb_clk_i;

  always @(posedge wb_clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  always @(negedge wb_clk_i) begin
    if (!wb_rst_i && v5c_cs_n_o === 1'b0) begin
      cs_low_cnt <= cs_low_cnt + 1;
    end
  end

  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("Timeout: tests still running after %0d clock cycles", TIMEOUT_CYCLES);
    $display("Errors found");
    $finish;
  end

  function automatic smap_pkg::reg_byte_t next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state[7:0];
  endfunction

  task automatic compare_byte(input string name, input smap_pkg::reg_byte_t expected,
                              input smap_pkg::reg_byte_t actual);
    assert (actual === expected) else begin
      errors++;
      $display("Error at %0t: %s expected 0x%02h, got 0x%02h", $time, name, expected, actual);
    end
  endtask

  task automatic capture_pins();
    snap = {v5c_prog_n_o, v5c_init_n_o, v5c_init_n_oe_o, v5c_rdwr_n_o, v5c_cs_n_o, v5c_d_o};
  endtask

  task automatic check_pins();
    compare_byte("v5c_prog_n_o", {7'b0, exp_oregs[0]}, {7'b0, snap.prog_n});
    compare_byte("v5c_init_n_o", {7'b0, exp_oregs[1]}, {7'b0, snap.init_n});
    compare_byte("v5c_rdwr_n_o", {7'b0, exp_oregs[2]}, {7'b0, snap.rdwr_n});
    compare_byte("v5c_init_n_oe_o", {7'b0, exp_ctrl[0]}, {7'b0, snap.init_n_oe});
    compare_byte("v5c_d_o", exp_data, snap.d);
  endtask

  // Returns at the falling edge inside the ack cycle
  task automatic wait_ack();
    do begin
      @(negedge wb_clk_i);
    end while (wb_ack_o !== 1'b1);
  endtask

  task automatic release_bus();
    @(posedge wb_clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic write_reg(input smap_pkg::reg_addr_t adr, input smap_pkg::reg_byte_t dat);
    @(posedge wb_clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= 1'b1;
    wb_adr_i <= adr;
    wb_dat_i <= dat;
    wait_ack();
    capture_pins();
    release_bus();
  endtask

  task automatic read_reg(input smap_pkg::reg_addr_t adr, input smap_pkg::reg_byte_t expected);
    @(posedge wb_clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= 1'b0;
    wb_adr_i <= adr;
    wait_ack();
    compare_byte($sformatf("wb_dat_o (adr %0d)", adr), expected, wb_dat_o);
    release_bus();
  endtask

  task automatic reset_values();
    @(negedge wb_clk_i);
    capture_pins();
    exp_oregs = 8'h03;  // rdwr_n 0, init_n 1, prog_n 1
    exp_ctrl  = 8'h01;
    exp_data  = 8'h00;
    check_pins();
    compare_byte("v5c_cs_n_o", 8'h01, {7'b0, snap.cs_n});
    compare_byte("wb_ack_o", 8'h00, {7'b0, wb_ack_o});
    compare_byte("v5c_mode_o", 8'h06, {5'b0, v5c_mode_o});
    read_reg(`SMAP_REG_OREGS, exp_oregs);
    read_reg(`SMAP_REG_CTRL, exp_ctrl);
    read_reg(`SMAP_REG_DATA, exp_data);
    read_reg(`SMAP_REG_STATUS, 8'h01);  // init_n high, done and busy low
  endtask

  task automatic pin_register();
    smap_pkg::reg_byte_t val;
    for (int i = 0; i < 8; i++) begin
      val = next_random();
      exp_oregs = {5'b0, val[2:0]};  // Upper bits are dropped
      write_reg(`SMAP_REG_OREGS, val);
      check_pins();
      read_reg(`SMAP_REG_OREGS, exp_oregs);
    end
  endtask

  task automatic control_register();
    int cs_before;
    exp_ctrl = 8'h00;
    write_reg(`SMAP_REG_CTRL, 8'hfe);
    check_pins();
    read_reg(`SMAP_REG_CTRL, exp_ctrl);
    exp_ctrl = 8'h01;
    write_reg(`SMAP_REG_CTRL, 8'h01);
    check_pins();
    read_reg(`SMAP_REG_CTRL, exp_ctrl);
    // STATUS is read only
    cs_before = cs_low_cnt;
    write_reg(`SMAP_REG_STATUS, 8'hff);
    check_pins();
    read_reg(`SMAP_REG_OREGS, exp_oregs);
    read_reg(`SMAP_REG_CTRL, exp_ctrl);
    read_reg(`SMAP_REG_DATA, exp_data);
    assert (cs_low_cnt == cs_before) else begin
      errors++;
      $display("Error at %0t: a write to STATUS pulled v5c_cs_n_o low", $time);
    end
  endtask

  task automatic data_writes();
    smap_pkg::reg_byte_t val;
    int                  cs_before;
    for (int i = 0; i < 16; i++) begin
      val = next_random();
      cs_before = cs_low_cnt;
      exp_data = val;
      write_reg(`SMAP_REG_DATA, val);
      check_pins();
      compare_byte("v5c_cs_n_o", 8'h00, {7'b0, snap.cs_n});  // Low together with ack
      read_reg(`SMAP_REG_DATA, exp_data);
      assert (cs_low_cnt - cs_before == 1) else begin
        errors++;
        $display("Error at %0t: data write %0d gave %0d low cycles on v5c_cs_n_o, not one",
                 $time, i, cs_low_cnt - cs_before);
      end
    end
  endtask

  task automatic status_sync();
    smap_pkg::reg_byte_t val;
    for (int i = 0; i < 4; i++) begin
      val = next_random();
      @(posedge wb_clk_i);
      v5c_busy_i   <= val[2];
      v5c_done_i   <= val[1];
      v5c_init_n_i <= val[0];
      repeat (3) @(posedge wb_clk_i);
      read_reg(`SMAP_REG_STATUS, {5'b0, val[2:0]});
    end
  endtask

  task automatic external_strobe();
    int cs_before;
    cs_before = cs_low_cnt;
    @(posedge wb_clk_i);
    sm_cs_n_i <= 1'b0;
    @(negedge wb_clk_i);
    compare_byte("v5c_cs_n_o", 8'h00, {7'b0, v5c_cs_n_o});
    @(posedge wb_clk_i);
    sm_cs_n_i <= 1'b1;
    @(negedge wb_clk_i);
    compare_byte("v5c_cs_n_o", 8'h01, {7'b0, v5c_cs_n_o});
    repeat (2) @(negedge wb_clk_i);
    compare_byte("v5c_d_o", exp_data, v5c_d_o);
    assert (cs_low_cnt - cs_before == 1) else begin
      errors++;
      $display("Error at %0t: external strobe gave %0d low cycles on v5c_cs_n_o, not one",
               $time, cs_low_cnt - cs_before);
    end
  endtask

  initial begin
    $timeformat(-9, 1, " ns", 0);
    errors    = 0;
    rng_state = 32'd57;
    wb_rst_i     <= 1'b1;
    wb_cyc_i     <= 1'b0;
    wb_stb_i     <= 1'b0;
    wb_we_i      <= 1'b0;
    wb_adr_i     <= '0;
    wb_dat_i     <= '0;
    sm_cs_n_i    <= 1'b1;
    v5c_done_i   <= 1'b0;
    v5c_busy_i   <= 1'b0;
    v5c_init_n_i <= 1'b1;
    repeat (8) @(posedge wb_clk_i);
    wb_rst_i <= 1'b0;

    reset_values();
    pin_register();
    control_register();
    data_writes();
    status_sync();
    external_strobe();

    repeat (2) @(posedge wb_clk_i);
    $display("Summary: %0d check errors, %0d assertion failures",
             errors, dut.u_asserts.fail_cnt);
    if (errors == 0 && dut.u_asserts.fail_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
smap_pkg.sv
wb_decode.sv
smap_ctrl.sv
smap_data.sv
smap_readback.sv
smap_cfg_top.sv
smap_cfg_asserts.sv
smap_cfg_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module smap_cfg_tb -f build.f -o smap_cfg_sim

sim_out=$(./obj_dir/smap_cfg_sim)
echo "$sim_out"

if grep -qx "No errors" <<< "$sim_out"; then
  exit 0
fi
exit 1
